/* Makefile */
# Verilator build and run for the uart core testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "test FAILED, no result"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
common/uart_pkg.sv
common/rx_frame_if.sv
rx/uart_rx.sv
rx/rx_status.sv
tx/uart_tx.sv
verilog/uart_core.sv
tests/uart_assert.sv
tests/uart_checker.sv
tests/tb_uart.sv

/* common/rx_frame_if.sv */
`default_nettype none

// frame report from the receiver to the status register
// frame_valid is a one-cycle strobe, the rest is only meaningful in that cycle
interface rx_frame_if import uart_pkg::*; ();

	uart_byte_t frame_data;	// assembled byte
	logic       frame_valid;	// strobe, no back-pressure
	logic       parity_err;	// low when parity is off
	logic       frame_err;	// a sampled stop bit was low

	modport rx_src (
		output frame_data, frame_valid, parity_err, frame_err
	);

	modport stat_dst (
		input frame_data, frame_valid, parity_err, frame_err
	);

endinterface

`default_nettype wire

/* common/uart_pkg.sv */
`default_nettype none

// shared frame constants, widths and state encodings for the uart core
package uart_pkg;

	// all timing counted in baud_tick cycles
	localparam int OVERSAMPLE = 16;	// ticks per serial bit
	localparam int MID_SAMPLE = 8;	// tick inside a bit where the line is sampled
	localparam int DATA_BITS  = 8;	// data length is fixed

	typedef logic [DATA_BITS-1:0] uart_byte_t;	// one data byte
	// counter wraps on its own since OVERSAMPLE is a power of two
	typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;
	typedef logic [$clog2(DATA_BITS)-1:0]  bit_idx_t;	// current data bit

	// transmit sequencer, one state per frame field
	typedef enum logic [2:0] {
		TX_IDLE,	// line held high, waiting for tx_start_i
		TX_START,
		TX_DATA,
		TX_PARITY,	// only when parity is enabled
		TX_STOP1,
		TX_STOP2	// only with two stop bits
	} tx_state_t;

	// receive sequencer, mirrors the transmit one
	typedef enum logic [2:0] {
		RX_IDLE,	// looking for a falling edge
		RX_START,	// qualifying the start bit at mid-bit
		RX_DATA,
		RX_PARITY,
		RX_STOP1,
		RX_STOP2
	} rx_state_t;

endpackage

`default_nettype wire

/* rx/rx_status.sv */
`default_nettype none

// receive holding register with ready, error and overrun flags
module rx_status import uart_pkg::*; (
	input  wire logic    baud_tick,
	input  wire logic    PRESETn,
	rx_frame_if.stat_dst frame_i,
	input  wire logic    rx_ack_i,	// software has read the byte
	output uart_byte_t   rx_data_o,
	output logic         rx_ready_o,
	output logic         rx_parity_err_o,
	output logic         rx_frame_err_o,
	output logic         rx_overrun_o
);

	logic new_frame;	// report arrives this cycle

	assign new_frame = frame_i.frame_valid;

	// last byte always replaces the held one
	always_ff @(posedge baud_tick) begin
		if (new_frame)
			rx_data_o <= frame_i.frame_data;
	end

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			rx_ready_o      <= 1'b0;
			rx_parity_err_o <= 1'b0;
			rx_frame_err_o  <= 1'b0;
			rx_overrun_o    <= 1'b0;
		end else if (new_frame) begin
			rx_ready_o      <= 1'b1;	// frame wins over a same-cycle ack
			rx_parity_err_o <= frame_i.parity_err;
			rx_frame_err_o  <= frame_i.frame_err;
			// overwriting an unread byte, an ack in this cycle means it was read
			rx_overrun_o    <= rx_ready_o && !rx_ack_i;
		end else if (rx_ack_i) begin
			rx_ready_o   <= 1'b0;
			rx_overrun_o <= 1'b0;	// error flags stay until the next frame
		end
	end

endmodule

`default_nettype wire

/* rx/uart_rx.sv */
`default_nettype none

// serial receiver
// two-flop sync, falling edge start, mid-bit start check and per-bit sampling
module uart_rx import uart_pkg::*; (
	input  wire logic baud_tick,
	input  wire logic PRESETn,
	input  wire logic parity_en_i,	// expect a parity bit after the data
	input  wire logic parity_odd_i,	// 1 odd, 0 even
	input  wire logic stop_two_i,	// expect two stop bits
	input  wire logic uart_rxd_i,	// asynchronous serial line
	rx_frame_if.rx_src frame_o
);

	logic [1:0] sync;	// sync[1] is safe to use
	logic       rxd_s;	// synchronized line
	logic       rxd_d;	// previous synchronized value for edge detect
	rx_state_t  state;
	tick_cnt_t  tick;
	bit_idx_t   bit_idx;
	uart_byte_t shreg;	// data shifts in from the top, lsb arrives first
	logic       par_acc;	// running xor of the data bits
	logic       par_bad;	// result of the parity check
	logic       stop_bad;	// first of two stop bits was low
	logic       sample_now;	// mid-bit of a data, parity or stop bit
	logic       last_stop;	// in the final stop bit of this frame

	assign rxd_s      = sync[1];
	assign sample_now = (tick == tick_cnt_t'(OVERSAMPLE - 1));
	assign last_stop  = (state == RX_STOP2) || (state == RX_STOP1 && !stop_two_i);

	// report is presented while the last stop bit is sampled
	assign frame_o.frame_valid = last_stop && sample_now;
	assign frame_o.frame_data  = shreg;
	assign frame_o.parity_err  = parity_en_i && par_bad;
	assign frame_o.frame_err   = !rxd_s || (stop_two_i && stop_bad);	// either stop bit low

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			sync    <= 2'b11;	// idle line is high
			rxd_d   <= 1'b1;
			state   <= RX_IDLE;
			tick    <= '0;
			bit_idx <= '0;
		end else begin
			sync  <= {sync[0], uart_rxd_i};
			rxd_d <= rxd_s;
			case (state)
				RX_IDLE: begin
					tick    <= tick_cnt_t'(1);	// edge cycle counts as the first tick
					bit_idx <= '0;
					// a falling edge needs the line high first, so a stuck low line is ignored
					if (rxd_d && !rxd_s)
						state <= RX_START;
				end
				RX_START: begin
					tick <= tick + 1'b1;
					if (tick == tick_cnt_t'(MID_SAMPLE)) begin
						tick  <= '0;	// later samples fall OVERSAMPLE ticks apart
						state <= rxd_s ? RX_IDLE : RX_DATA;	// high again means a glitch
					end
				end
				default: begin
					tick <= tick + 1'b1;	// wraps to zero on the sample tick
					if (sample_now) begin
						case (state)
							RX_DATA: begin
								if (bit_idx == bit_idx_t'(DATA_BITS - 1))
									state <= parity_en_i ? RX_PARITY : RX_STOP1;
								else
									bit_idx <= bit_idx + 1'b1;
							end
							RX_PARITY: state <= RX_STOP1;
							RX_STOP1:  state <= stop_two_i ? RX_STOP2 : RX_IDLE;
							default:   state <= RX_IDLE;	// end of RX_STOP2
						endcase
					end
				end
			endcase
		end
	end

	// data path, only touched at sample points
	always_ff @(posedge baud_tick) begin
		if (state == RX_IDLE) begin
			par_acc <= 1'b0;
		end else if (sample_now) begin
			case (state)
				RX_DATA: begin
					shreg   <= {rxd_s, shreg[DATA_BITS-1:1]};
					par_acc <= par_acc ^ rxd_s;
				end
				// ones count incl parity must be even, or odd when parity_odd_i is set
				RX_PARITY: par_bad  <= par_acc ^ rxd_s ^ parity_odd_i;
				RX_STOP1:  stop_bad <= !rxd_s;	// only read in two-stop mode
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* tests/tb_uart.sv */
`default_nettype none

// testbench top for the uart core
module tb_uart;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {M_LOOP, M_BAD_PAR, M_BAD_STOP, M_GLITCH, M_NO_ACK} mode_t;

	typedef struct packed {
		logic [7:0] data;
		logic       pen;
		logic       podd;
		logic       stop2;
		mode_t      mode;
		logic       perr;	// expected parity error
		logic       ferr;	// expected framing error
	} row_t;

	logic       baud_tick;
	logic       PRESETn;
	logic       parity_en, parity_odd, stop_two;
	logic       tx_start, rx_ack;
	logic [7:0] tx_data;
	logic       rx_line;	// bit-banged line
	logic       loop_mode;	// txd feeds rxd
	logic       check;
	logic [7:0] exp_data;
	logic       exp_ready, exp_perr, exp_ferr, exp_ovr;
	logic [7:0] m_data;	// expected status model
	logic       m_ready, m_perr, m_ferr, m_ovr;
	wire        rxd, uart_txd, tx_busy, rx_ready, rx_perr, rx_ferr, rx_ovr;
	wire  [7:0] rx_data;
	row_t        rows[$];
	logic [31:0] lfsr = 32'h7e78;
	int          cycles = 0;
	int          limit = 0;	// set once the table is built
	int          tx_errs, rx_errs;

	assign rxd = loop_mode ? uart_txd : rx_line;

	uart_core uut (
		.baud_tick (baud_tick), .PRESETn (PRESETn),
		.parity_en_i (parity_en), .parity_odd_i (parity_odd), .stop_two_i (stop_two),
		.tx_start_i (tx_start), .tx_data_i (tx_data), .uart_rxd_i (rxd), .rx_ack_i (rx_ack),
		.uart_txd_o (uart_txd), .tx_busy_o (tx_busy), .rx_data_o (rx_data),
		.rx_ready_o (rx_ready), .rx_parity_err_o (rx_perr), .rx_frame_err_o (rx_ferr),
		.rx_overrun_o (rx_ovr)
	);

	uart_checker u_check (
		.baud_tick (baud_tick), .PRESETn (PRESETn), .txd_i (uart_txd), .tx_busy_i (tx_busy),
		.tx_start_i (tx_start), .tx_data_i (tx_data), .parity_en_i (parity_en),
		.parity_odd_i (parity_odd), .stop_two_i (stop_two), .rx_data_i (rx_data),
		.rx_ready_i (rx_ready), .rx_perr_i (rx_perr), .rx_ferr_i (rx_ferr), .rx_ovr_i (rx_ovr),
		.check_i (check), .exp_data_i (exp_data), .exp_ready_i (exp_ready),
		.exp_perr_i (exp_perr), .exp_ferr_i (exp_ferr), .exp_ovr_i (exp_ovr),
		.tx_errs_o (tx_errs), .rx_errs_o (rx_errs)
	);

	initial begin
		baud_tick = 1'b0;
		forever #2 baud_tick = ~baud_tick;	// 4 ns period
	end

	// right-shifting form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		lfsr = galois_step(lfsr);
		return lfsr[0];
	endfunction

	function automatic logic [7:0] take_byte();
		logic [7:0] b;
		for (int k = 0; k < 8; k++)
			b[k] = take_bit();
		return b;
	endfunction

	task automatic add_row(input logic [7:0] d, input logic pen, input logic podd,
			input logic stop2, input mode_t mode, input logic perr, input logic ferr);
		rows.push_back(row_t'{d, pen, podd, stop2, mode, perr, ferr});
	endtask

	// hand the model to the checker for one cycle
	task automatic check_status();
		exp_data  <= m_data;
		exp_ready <= m_ready;
		exp_perr  <= m_perr;
		exp_ferr  <= m_ferr;
		exp_ovr   <= m_ovr;
		check     <= 1'b1;
		@(posedge baud_tick);
		check <= 1'b0;
	endtask

	task automatic wait_tx_idle();
		@(posedge baud_tick);	// busy is visible from here on
		while (tx_busy)
			@(posedge baud_tick);
	endtask

	// bit-bang one frame with the row's faults at 16 cycles per bit
	task automatic send_frame(input row_t r);
		logic [11:0] bits;
		int          n;
		bits = {3'b111, r.data, 1'b0};	// stop bits high by default
		n    = 10 + int'(r.pen) + int'(r.stop2);
		if (r.pen)
			bits[9] = (^r.data) ^ r.podd ^ (r.mode == M_BAD_PAR);	// inverted when bad
		if (r.mode == M_BAD_STOP)
			bits[n - 1] = 1'b0;	// last stop bit which is the second one with two stops
		for (int k = 0; k < n; k++) begin
			rx_line <= bits[k];
			repeat (16) @(posedge baud_tick);
		end
		rx_line <= 1'b1;
	endtask

	task automatic run_row(input row_t r);
		repeat (4) @(posedge baud_tick);	// idle gap with the line high
		loop_mode  <= (r.mode == M_LOOP);
		parity_en  <= r.pen;
		parity_odd <= r.podd;
		stop_two   <= r.stop2;
		if (r.mode == M_GLITCH) begin
			rx_line <= 1'b0;	// short low pulse that must not start a frame
			repeat (4) @(posedge baud_tick);
			rx_line <= 1'b1;
			repeat (12 * 16) @(posedge baud_tick);	// longer than any frame a false start could make
			check_status();
		end
		tx_data  <= r.data;
		tx_start <= 1'b1;
		@(posedge baud_tick);
		tx_start <= 1'b0;
		fork
			wait_tx_idle();
			if (r.mode != M_LOOP)
				send_frame(r);
		join
		repeat (2) @(posedge baud_tick);
		m_ovr   = m_ready;	// unread byte gets replaced
		m_ready = 1'b1;
		m_data  = r.data;
		m_perr  = r.perr;
		m_ferr  = r.ferr;
		check_status();
		if (r.mode != M_NO_ACK) begin
			rx_ack <= 1'b1;
			@(posedge baud_tick);
			rx_ack  <= 1'b0;
			m_ready = 1'b0;
			m_ovr   = 1'b0;	// data and error flags stay
			check_status();
		end
	endtask

	always @(posedge baud_tick) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		PRESETn    = 1'b0;
		parity_en  = 1'b0;
		parity_odd = 1'b0;
		stop_two   = 1'b0;
		tx_start   = 1'b0;
		tx_data    = 8'h00;
		rx_ack     = 1'b0;
		rx_line    = 1'b1;
		loop_mode  = 1'b0;
		check      = 1'b0;
		{exp_data, exp_ready, exp_perr, exp_ferr, exp_ovr} = '0;
		{m_data, m_ready, m_perr, m_ferr, m_ovr} = '0;
		//      byte   pen podd st2 mode        perr ferr
		add_row(8'h55, 0, 0, 0, M_LOOP,     0, 0);
		add_row(8'hA7, 1, 0, 0, M_LOOP,     0, 0);
		add_row(8'h3C, 1, 1, 1, M_LOOP,     0, 0);
		add_row(8'h96, 1, 0, 0, M_BAD_PAR,  1, 0);
		add_row(8'h0F, 1, 1, 1, M_BAD_PAR,  1, 0);
		add_row(8'hE1, 0, 0, 0, M_BAD_STOP, 0, 1);
		add_row(8'h72, 1, 1, 1, M_BAD_STOP, 0, 1);	// second stop bit low
		add_row(8'h18, 0, 0, 1, M_NO_ACK,   0, 0);
		add_row(8'hC3, 1, 0, 0, M_LOOP,     0, 0);	// overrun on top of 8'h18
		add_row(8'h00, 0, 0, 0, M_GLITCH,   0, 0);
		add_row(8'hFF, 1, 1, 0, M_NO_ACK,   0, 0);
		add_row(8'h81, 0, 0, 1, M_GLITCH,   0, 0);	// glitch while ready then overrun
		for (int i = 0; i < 4; i++)
			add_row(take_byte(), take_bit(), take_bit(), take_bit(), M_LOOP, 0, 0);
		limit = rows.size() * 12 * 16 * 2 + 500;
		repeat (3) @(posedge baud_tick);
		PRESETn <= 1'b1;
		for (int i = 0; i < rows.size(); i++)
			run_row(rows[i]);
		repeat (4) @(posedge baud_tick);
		$display("tx errors: %0d, rx errors: %0d", tx_errs, rx_errs);
		if (tx_errs + rx_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/uart_assert.sv */
`default_nettype none

// protocol rules on the core ports, bound into uart_core
module uart_assert import uart_pkg::*; (
	input wire logic baud_tick,
	input wire logic PRESETn,
	input wire logic txd_i,
	input wire logic tx_busy_i,
	input wire logic rx_ready_i,
	input wire logic rx_overrun_i
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MIN_FRAME = OVERSAMPLE * (DATA_BITS + 2);	// start, data, one stop
	localparam int MAX_FRAME = OVERSAMPLE * (DATA_BITS + 4);	// plus parity and second stop

	int busy_len;	// cycles the current frame has been busy

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn)
			busy_len <= 0;
		else if (tx_busy_i)
			busy_len <= busy_len + 1;
		else
			busy_len <= 0;
	end

	idle_line_high: assert property (@(posedge baud_tick) disable iff (!PRESETn)
		!tx_busy_i |-> txd_i)
		else $error("tx line low while the transmitter is idle");

	overrun_needs_ready: assert property (@(posedge baud_tick) disable iff (!PRESETn)
		rx_overrun_i |-> rx_ready_i)
		else $error("rx_overrun_o set without rx_ready_o");

	// whole number of bits, between the shortest and longest frame
	busy_whole_frame: assert property (@(posedge baud_tick) disable iff (!PRESETn)
		$fell(tx_busy_i) |-> (busy_len >= MIN_FRAME) && (busy_len <= MAX_FRAME)
			&& (busy_len % OVERSAMPLE == 0))
		else $error("tx_busy_o dropped in the middle of a frame");

endmodule

bind uart_core uart_assert u_assert (
	.baud_tick    (baud_tick),
	.PRESETn      (PRESETn),
	.txd_i        (uart_txd_o),
	.tx_busy_i    (tx_busy_o),
	.rx_ready_i   (rx_ready_o),
	.rx_overrun_i (rx_overrun_o)
);

`default_nettype wire

/* tests/uart_checker.sv */
`default_nettype none

// watches the core, decodes the tx line and compares status against the expected values
module uart_checker import uart_pkg::*; (
	input  wire logic       baud_tick,
	input  wire logic       PRESETn,
	input  wire logic       txd_i,
	input  wire logic       tx_busy_i,
	input  wire logic       tx_start_i,
	input  wire uart_byte_t tx_data_i,
	input  wire logic       parity_en_i,
	input  wire logic       parity_odd_i,
	input  wire logic       stop_two_i,
	input  wire uart_byte_t rx_data_i,
	input  wire logic       rx_ready_i,
	input  wire logic       rx_perr_i,
	input  wire logic       rx_ferr_i,
	input  wire logic       rx_ovr_i,
	input  wire logic       check_i,	// compare status this cycle
	input  wire uart_byte_t exp_data_i,
	input  wire logic       exp_ready_i,
	input  wire logic       exp_perr_i,
	input  wire logic       exp_ferr_i,
	input  wire logic       exp_ovr_i,
	output int              tx_errs_o,
	output int              rx_errs_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int          tx_errs = 0;
	int          rx_errs = 0;
	int          tx_cnt;	// cycles since the accepting edge
	int          tx_bits;	// frame length in bits
	int          busy_len;
	logic        tx_active = 1'b0;
	logic [11:0] tx_frame;	// expected line level per bit from the start bit up

	assign tx_errs_o = tx_errs;
	assign rx_errs_o = rx_errs;

	task automatic compare(input string name, input logic [7:0] exp,
			input logic [7:0] act, input bit is_tx);
		if (act !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
			if (is_tx)
				tx_errs++;
			else
				rx_errs++;
		end
	endtask

	always @(posedge baud_tick) begin
		if (tx_active) begin
			tx_cnt++;
			if (!tx_busy_i || tx_cnt > OVERSAMPLE * tx_bits) begin
				busy_len = tx_busy_i ? tx_cnt : tx_cnt - 1;	// still high means too long
				if (busy_len != OVERSAMPLE * tx_bits) begin
					$display("error at %0t: tx_busy_o high for %0d cycles, expected %0d",
						$time, busy_len, OVERSAMPLE * tx_bits);
					tx_errs++;
				end
				tx_active = 1'b0;
			end else if (tx_cnt % OVERSAMPLE == MID_SAMPLE) begin
				compare("uart_txd_o", 8'(tx_frame[tx_cnt / OVERSAMPLE]), 8'(txd_i), 1'b1);
			end
		end
		// busy and the start bit follow an accepted start on this edge
		if (PRESETn && tx_start_i && !tx_busy_i) begin
			tx_frame = {3'b111, tx_data_i, 1'b0};
			// ones in data and parity bit together are odd only for odd parity
			if (parity_en_i)
				tx_frame[9] = (($countones(tx_data_i) + int'(parity_odd_i)) % 2) == 1;
			tx_bits   = 10 + int'(parity_en_i) + int'(stop_two_i);
			tx_cnt    = 0;
			tx_active = 1'b1;
		end
		if (check_i) begin
			compare("rx_data_o", exp_data_i, rx_data_i, 1'b0);
			compare("rx_ready_o", 8'(exp_ready_i), 8'(rx_ready_i), 1'b0);
			compare("rx_parity_err_o", 8'(exp_perr_i), 8'(rx_perr_i), 1'b0);
			compare("rx_frame_err_o", 8'(exp_ferr_i), 8'(rx_ferr_i), 1'b0);
			compare("rx_overrun_o", 8'(exp_ovr_i), 8'(rx_ovr_i), 1'b0);
		end
	end

endmodule

`default_nettype wire

/* tx/uart_tx.sv */
`default_nettype none

// serial transmitter
// start bit, 8 data bits lsb first, optional parity, one or two stop bits
module uart_tx import uart_pkg::*; (
	input  wire logic       baud_tick,
	input  wire logic       PRESETn,
	input  wire logic       parity_en_i,
	input  wire logic       parity_odd_i,	// 1 odd, 0 even
	input  wire logic       stop_two_i,
	input  wire logic       tx_start_i,	// ignored while busy
	input  wire uart_byte_t tx_data_i,
	output logic            uart_txd_o,	// registered, no glitches
	output logic            tx_busy_o
);

	tx_state_t  state;
	tick_cnt_t  tick;	// position inside the current bit
	bit_idx_t   bit_idx;
	uart_byte_t shreg;	// bit 0 is the one on the line during TX_DATA
	logic       par_bit;	// parity for the frame in flight
	logic       bit_end;	// sixteenth tick of the current bit
	logic       start_ok;	// request accepted this cycle

	assign bit_end  = (tick == tick_cnt_t'(OVERSAMPLE - 1));
	assign start_ok = tx_start_i && !tx_busy_o;

	// byte latched on accept, shifted right after each data bit
	always_ff @(posedge baud_tick) begin
		if (start_ok) begin
			shreg   <= tx_data_i;
			par_bit <= (^tx_data_i) ^ parity_odd_i;	// odd parity inverts the plain xor
		end else if (state == TX_DATA && bit_end) begin
			shreg <= shreg >> 1;
		end
	end

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			state      <= TX_IDLE;
			tick       <= '0;
			bit_idx    <= '0;
			tx_busy_o  <= 1'b0;
			uart_txd_o <= 1'b1;	// idle line
		end else if (state == TX_IDLE) begin
			tick    <= '0;
			bit_idx <= '0;
			if (start_ok) begin
				state      <= TX_START;
				tx_busy_o  <= 1'b1;	// busy and start bit on the same edge
				uart_txd_o <= 1'b0;
			end
		end else begin
			tick <= tick + 1'b1;	// wraps after OVERSAMPLE ticks
			if (bit_end) begin
				case (state)
					TX_START: begin
						state      <= TX_DATA;
						uart_txd_o <= shreg[0];
					end
					TX_DATA: begin
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							state      <= parity_en_i ? TX_PARITY : TX_STOP1;
							uart_txd_o <= parity_en_i ? par_bit : 1'b1;
						end else begin
							bit_idx    <= bit_idx + 1'b1;
							uart_txd_o <= shreg[1];	// next bit before the shift lands
						end
					end
					TX_PARITY: begin
						state      <= TX_STOP1;
						uart_txd_o <= 1'b1;
					end
					TX_STOP1: begin
						if (stop_two_i) begin
							state <= TX_STOP2;	// line stays high
						end else begin
							state     <= TX_IDLE;
							tx_busy_o <= 1'b0;
						end
					end
					default: begin	// end of TX_STOP2
						state     <= TX_IDLE;
						tx_busy_o <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_core.sv */
`default_nettype none

// uart core top
// receiver feeds the status register over rx_frame_if, transmitter runs on its own
module uart_core import uart_pkg::*; (
	input  wire logic       baud_tick,	// 16x bit rate
	input  wire logic       PRESETn,
	input  wire logic       parity_en_i,	// frame options, shared by rx and tx
	input  wire logic       parity_odd_i,
	input  wire logic       stop_two_i,
	input  wire logic       tx_start_i,
	input  wire uart_byte_t tx_data_i,
	input  wire logic       uart_rxd_i,
	input  wire logic       rx_ack_i,
	output logic            uart_txd_o,
	output logic            tx_busy_o,
	output uart_byte_t      rx_data_o,
	output logic            rx_ready_o,
	output logic            rx_parity_err_o,
	output logic            rx_frame_err_o,
	output logic            rx_overrun_o
);

	rx_frame_if frame_bus ();	// rx to status

	uart_rx u_rx (
		.baud_tick    (baud_tick),
		.PRESETn      (PRESETn),
		.parity_en_i  (parity_en_i),
		.parity_odd_i (parity_odd_i),
		.stop_two_i   (stop_two_i),
		.uart_rxd_i   (uart_rxd_i),
		.frame_o      (frame_bus.rx_src)
	);

	rx_status u_status (
		.baud_tick       (baud_tick),
		.PRESETn         (PRESETn),
		.frame_i         (frame_bus.stat_dst),
		.rx_ack_i        (rx_ack_i),
		.rx_data_o       (rx_data_o),
		.rx_ready_o      (rx_ready_o),
		.rx_parity_err_o (rx_parity_err_o),
		.rx_frame_err_o  (rx_frame_err_o),
		.rx_overrun_o    (rx_overrun_o)
	);

	uart_tx u_tx (
		.baud_tick    (baud_tick),
		.PRESETn      (PRESETn),
		.parity_en_i  (parity_en_i),
		.parity_odd_i (parity_odd_i),
		.stop_two_i   (stop_two_i),
		.tx_start_i   (tx_start_i),
		.tx_data_i    (tx_data_i),
		.uart_txd_o   (uart_txd_o),
		.tx_busy_o    (tx_busy_o)
	);

endmodule

`default_nettype wire
